/* verilog/dma_ctrl_config.svh */
`ifndef DMA_CTRL_CONFIG_SVH
`define DMA_CTRL_CONFIG_SVH

// descriptor field widths
`define DMA_PCIE_ADDR_W 64
`define DMA_AXI_ADDR_W 32
`define DMA_LEN_W 16
`define DMA_TAG_W 8

// register bus
`define REG_ADDR_W 16
`define REG_DATA_W 32

`define FRAME_COUNT_W 32

`define STATUS_FIFO_DEPTH 4
`define ERR_SRC_COUNT 3
`define ERR_COUNT_W 4

// byte offsets, word aligned
`define REG_DMA_CTRL 16'h0000
`define REG_RD_PCIE_LO 16'h0100
`define REG_RD_PCIE_HI 16'h0104
`define REG_RD_AXI 16'h0108
`define REG_RD_LEN 16'h0110
`define REG_RD_TAG 16'h0114
`define REG_RD_STATUS 16'h0118
`define REG_WR_PCIE_LO 16'h0200
`define REG_WR_PCIE_HI 16'h0204
`define REG_WR_AXI 16'h0208
`define REG_WR_LEN 16'h0210
`define REG_WR_TAG 16'h0214
`define REG_WR_STATUS 16'h0218
`define REG_CNT_RQ 16'h0400
`define REG_CNT_RC 16'h0404
`define REG_CNT_CQ 16'h0408
`define REG_CNT_CC 16'h040C

`endif

/* verilog/dma_ctrl_pkg.sv */
`default_nettype none

`include "dma_ctrl_config.svh"

package dma_ctrl_pkg;

    // completion status word, built by the queue and read back raw
    typedef union packed {
        logic [`REG_DATA_W-1:0] raw;
        struct packed {
            logic                                done;
            logic [`REG_DATA_W-`DMA_TAG_W-2:0] reserved;
            logic [`DMA_TAG_W-1:0]             tag;
        } fields;
    } dma_status_word_t;

endpackage

`default_nettype wire

/* verilog/error_pulse_merge.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module error_pulse_merge #(
    parameter int INPUT_WIDTH = `ERR_SRC_COUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INPUT_WIDTH-1:0] pulse_in,
    output logic                   pulse_out
);

    localparam int COUNT_W = `ERR_COUNT_W;
    localparam int SUM_W = COUNT_W + 1;

    logic [COUNT_W-1:0] count;
    logic [SUM_W-1:0]   sum;

    // pending pulses including this cycle's arrivals
    assign sum = {1'b0, count} + SUM_W'($countones(pulse_in));

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            pulse_out <= 1'b0;
        end else begin
            pulse_out <= sum != '0;
            if (sum != '0) begin
                // one pulse leaves per cycle
                count <= COUNT_W'(sum - 1'b1);
            end
        end
    end

    // sources must not outrun the drain by more than the counter holds
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        sum <= SUM_W'(2 ** COUNT_W));

endmodule

`default_nettype wire

/* verilog/dma_frame_counters.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module dma_frame_counters (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rq_valid,
    input  logic                      rq_ready,
    input  logic                      rq_last,
    input  logic                      rc_valid,
    input  logic                      rc_ready,
    input  logic                      rc_last,
    input  logic                      cq_valid,
    input  logic                      cq_ready,
    input  logic                      cq_last,
    input  logic                      cc_valid,
    input  logic                      cc_ready,
    input  logic                      cc_last,
    output logic [`FRAME_COUNT_W-1:0] cnt_rq,
    output logic [`FRAME_COUNT_W-1:0] cnt_rc,
    output logic [`FRAME_COUNT_W-1:0] cnt_cq,
    output logic [`FRAME_COUNT_W-1:0] cnt_cc
);

    logic [3:0]                frame_end;
    logic [`FRAME_COUNT_W-1:0] count [4];

    // last beat actually transferred
    assign frame_end[0] = rq_valid && rq_ready && rq_last;
    assign frame_end[1] = rc_valid && rc_ready && rc_last;
    assign frame_end[2] = cq_valid && cq_ready && cq_last;
    assign frame_end[3] = cc_valid && cc_ready && cc_last;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                count[i] <= '0;
            end else if (frame_end[i]) begin
                count[i] <= count[i] + 1'b1;
            end
        end
    end

    assign cnt_rq = count[0];
    assign cnt_rc = count[1];
    assign cnt_cq = count[2];
    assign cnt_cc = count[3];

endmodule

`default_nettype wire

/* verilog/dma_status_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module dma_status_fifo (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           status_valid,
    input  logic [`DMA_TAG_W-1:0]          status_tag,
    output logic                           status_ready,
    input  logic                           pop,
    output dma_ctrl_pkg::dma_status_word_t head
);

    localparam int DEPTH = `STATUS_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`DMA_TAG_W-1:0] tag_mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push;

    assign status_ready = count != CNT_W'(DEPTH);
    assign push = status_valid && status_ready;

    // empty queue reads as an all-zero word
    always_comb begin
        head = '0;
        head.fields.done = count != '0;
        head.fields.tag = (count != '0) ? tag_mem[rd_ptr] : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr] <= status_tag;
        end
    end

    // register block only pops a head marked done
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> count != '0);

endmodule

`default_nettype wire

/* verilog/dma_ctrl_regs.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module dma_ctrl_regs (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             req_valid,
    input  logic                             req_write,
    input  logic [`REG_ADDR_W-1:0]           req_addr,
    input  logic [`REG_DATA_W-1:0]           req_wdata,
    output logic                             req_ready,
    output logic                             rsp_valid,
    output logic [`REG_DATA_W-1:0]           rsp_rdata,
    input  logic                             rsp_ready,

    output logic                             dma_enable,

    output logic [`DMA_PCIE_ADDR_W-1:0]      rd_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]       rd_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]            rd_desc_len,
    output logic [`DMA_TAG_W-1:0]            rd_desc_tag,
    output logic                             rd_desc_valid,
    input  logic                             rd_desc_ready,

    output logic [`DMA_PCIE_ADDR_W-1:0]      wr_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]       wr_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]            wr_desc_len,
    output logic [`DMA_TAG_W-1:0]            wr_desc_tag,
    output logic                             wr_desc_valid,
    input  logic                             wr_desc_ready,

    input  dma_ctrl_pkg::dma_status_word_t   rd_head,
    input  dma_ctrl_pkg::dma_status_word_t   wr_head,
    output logic                             rd_pop,
    output logic                             wr_pop,

    input  logic [`FRAME_COUNT_W-1:0]        cnt_rq,
    input  logic [`FRAME_COUNT_W-1:0]        cnt_rc,
    input  logic [`FRAME_COUNT_W-1:0]        cnt_cq,
    input  logic [`FRAME_COUNT_W-1:0]        cnt_cc,

    output logic                             irq
);

    logic [`REG_ADDR_W-1:0]      word_addr;
    logic                        launch_stall;
    logic                        req_fire;
    logic                        status_read;
    logic [`REG_DATA_W-1:0]      ctrl_reg;
    logic [`REG_DATA_W-1:0]      rd_data;

    // staging registers, copied out on launch
    logic [`DMA_PCIE_ADDR_W-1:0] rd_stage_pcie;
    logic [`DMA_AXI_ADDR_W-1:0]  rd_stage_axi;
    logic [`DMA_LEN_W-1:0]       rd_stage_len;
    logic [`DMA_PCIE_ADDR_W-1:0] wr_stage_pcie;
    logic [`DMA_AXI_ADDR_W-1:0]  wr_stage_axi;
    logic [`DMA_LEN_W-1:0]       wr_stage_len;

    assign word_addr = {req_addr[`REG_ADDR_W-1:2], 2'b00};

    // hold a launch while the previous descriptor is still pending
    assign launch_stall = req_write &&
        ((word_addr == `REG_RD_TAG && rd_desc_valid) ||
         (word_addr == `REG_WR_TAG && wr_desc_valid));

    assign req_ready = !rsp_valid && !launch_stall;
    assign req_fire = req_valid && req_ready;
    assign status_read = req_fire && !req_write;

    assign rd_pop = status_read && word_addr == `REG_RD_STATUS && rd_head.fields.done;
    assign wr_pop = status_read && word_addr == `REG_WR_STATUS && wr_head.fields.done;

    assign dma_enable = ctrl_reg[0];
    assign irq = rd_head.fields.done || wr_head.fields.done;

    always_comb begin
        case (word_addr)
            `REG_DMA_CTRL:  rd_data = ctrl_reg;
            `REG_RD_STATUS: rd_data = rd_head.raw;
            `REG_WR_STATUS: rd_data = wr_head.raw;
            `REG_CNT_RQ:    rd_data = cnt_rq;
            `REG_CNT_RC:    rd_data = cnt_rc;
            `REG_CNT_CQ:    rd_data = cnt_cq;
            `REG_CNT_CC:    rd_data = cnt_cc;
            default:        rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
        if (req_fire) begin
            rsp_rdata <= req_write ? '0 : rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_reg      <= '0;
            rd_desc_valid <= 1'b0;
            wr_desc_valid <= 1'b0;
        end else begin
            if (rd_desc_ready) begin
                rd_desc_valid <= 1'b0;
            end
            if (wr_desc_ready) begin
                wr_desc_valid <= 1'b0;
            end
            if (req_fire && req_write) begin
                case (word_addr)
                    `REG_DMA_CTRL: ctrl_reg <= req_wdata;
                    `REG_RD_TAG:   rd_desc_valid <= 1'b1;
                    `REG_WR_TAG:   wr_desc_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && req_write) begin
            case (word_addr)
                `REG_RD_PCIE_LO: rd_stage_pcie[`REG_DATA_W-1:0] <= req_wdata;
                `REG_RD_PCIE_HI: rd_stage_pcie[`DMA_PCIE_ADDR_W-1:`REG_DATA_W] <= req_wdata;
                `REG_RD_AXI:     rd_stage_axi <= req_wdata[`DMA_AXI_ADDR_W-1:0];
                `REG_RD_LEN:     rd_stage_len <= req_wdata[`DMA_LEN_W-1:0];
                `REG_RD_TAG: begin
                    rd_desc_pcie_addr <= rd_stage_pcie;
                    rd_desc_axi_addr  <= rd_stage_axi;
                    rd_desc_len       <= rd_stage_len;
                    rd_desc_tag       <= req_wdata[`DMA_TAG_W-1:0];
                end
                `REG_WR_PCIE_LO: wr_stage_pcie[`REG_DATA_W-1:0] <= req_wdata;
                `REG_WR_PCIE_HI: wr_stage_pcie[`DMA_PCIE_ADDR_W-1:`REG_DATA_W] <= req_wdata;
                `REG_WR_AXI:     wr_stage_axi <= req_wdata[`DMA_AXI_ADDR_W-1:0];
                `REG_WR_LEN:     wr_stage_len <= req_wdata[`DMA_LEN_W-1:0];
                `REG_WR_TAG: begin
                    wr_desc_pcie_addr <= wr_stage_pcie;
                    wr_desc_axi_addr  <= wr_stage_axi;
                    wr_desc_len       <= wr_stage_len;
                    wr_desc_tag       <= req_wdata[`DMA_TAG_W-1:0];
                end
                default: ;
            endcase
        end
    end

    // descriptor handshake held until the engine takes it
    a_rd_desc_hold: assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid && $stable(rd_desc_tag));
    a_wr_desc_hold: assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid && $stable(wr_desc_tag));

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

`default_nettype wire

/* verilog/dma_ctrl_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module dma_ctrl_top (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [`REG_ADDR_W-1:0]        req_addr,
    input  logic [`REG_DATA_W-1:0]        req_wdata,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output logic [`REG_DATA_W-1:0]        rsp_rdata,
    input  logic                          rsp_ready,

    output logic                          dma_enable,

    output logic [`DMA_PCIE_ADDR_W-1:0]   rd_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]    rd_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]         rd_desc_len,
    output logic [`DMA_TAG_W-1:0]         rd_desc_tag,
    output logic                          rd_desc_valid,
    input  logic                          rd_desc_ready,

    output logic [`DMA_PCIE_ADDR_W-1:0]   wr_desc_pcie_addr,
    output logic [`DMA_AXI_ADDR_W-1:0]    wr_desc_axi_addr,
    output logic [`DMA_LEN_W-1:0]         wr_desc_len,
    output logic [`DMA_TAG_W-1:0]         wr_desc_tag,
    output logic                          wr_desc_valid,
    input  logic                          wr_desc_ready,

    input  logic                          rd_status_valid,
    input  logic [`DMA_TAG_W-1:0]         rd_status_tag,
    output logic                          rd_status_ready,
    input  logic                          wr_status_valid,
    input  logic [`DMA_TAG_W-1:0]         wr_status_tag,
    output logic                          wr_status_ready,

    input  logic                          rq_valid,
    input  logic                          rq_ready,
    input  logic                          rq_last,
    input  logic                          rc_valid,
    input  logic                          rc_ready,
    input  logic                          rc_last,
    input  logic                          cq_valid,
    input  logic                          cq_ready,
    input  logic                          cq_last,
    input  logic                          cc_valid,
    input  logic                          cc_ready,
    input  logic                          cc_last,

    input  logic [`ERR_SRC_COUNT-1:0]     err_cor,
    input  logic [`ERR_SRC_COUNT-1:0]     err_uncor,
    output logic                          err_cor_pulse,
    output logic                          err_uncor_pulse,
    output logic                          irq
);

    import dma_ctrl_pkg::*;

    dma_status_word_t          rd_head;
    dma_status_word_t          wr_head;
    logic                      rd_pop;
    logic                      wr_pop;
    logic [`FRAME_COUNT_W-1:0] cnt_rq;
    logic [`FRAME_COUNT_W-1:0] cnt_rc;
    logic [`FRAME_COUNT_W-1:0] cnt_cq;
    logic [`FRAME_COUNT_W-1:0] cnt_cc;

    dma_ctrl_regs i_dma_ctrl_regs (.*);

    dma_status_fifo i_rd_status (
        .clk          (clk),
        .rst          (rst),
        .status_valid (rd_status_valid),
        .status_tag   (rd_status_tag),
        .status_ready (rd_status_ready),
        .pop          (rd_pop),
        .head         (rd_head)
    );

    dma_status_fifo i_wr_status (
        .clk          (clk),
        .rst          (rst),
        .status_valid (wr_status_valid),
        .status_tag   (wr_status_tag),
        .status_ready (wr_status_ready),
        .pop          (wr_pop),
        .head         (wr_head)
    );

    dma_frame_counters i_dma_frame_counters (.*);

    error_pulse_merge #(
        .INPUT_WIDTH (`ERR_SRC_COUNT)
    ) i_err_cor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_cor),
        .pulse_out (err_cor_pulse)
    );

    error_pulse_merge #(
        .INPUT_WIDTH (`ERR_SRC_COUNT)
    ) i_err_uncor_merge (
        .clk       (clk),
        .rst       (rst),
        .pulse_in  (err_uncor),
        .pulse_out (err_uncor_pulse)
    );

endmodule

`default_nettype wire

/* verification/tb_dma_ctrl_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "dma_ctrl_config.svh"

module tb_dma_ctrl_top;

    localparam int DESC_W = `DMA_PCIE_ADDR_W + `DMA_AXI_ADDR_W + `DMA_LEN_W + `DMA_TAG_W;
    localparam int ADDR_W = `REG_ADDR_W;
    localparam int TAG_W = `DMA_TAG_W;
    localparam int ERR_W = `ERR_SRC_COUNT;
    localparam int DEPTH = `STATUS_FIFO_DEPTH;
    localparam int FRAME_BEATS = 400;
    localparam int ERR_BURSTS = 40;
    localparam int MAX_REG_ACCESSES = 64;
    // each access takes at most about 20 cycles including engine stalls
    localparam int WATCHDOG_CYCLES = MAX_REG_ACCESSES * 20 + FRAME_BEATS + 3 * ERR_BURSTS + 200;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic req_valid, req_write, req_ready, rsp_valid, rsp_ready;
    logic [`REG_ADDR_W-1:0] req_addr;
    logic [`REG_DATA_W-1:0] req_wdata, rsp_rdata;
    logic dma_enable, irq, err_cor_pulse, err_uncor_pulse;
    logic [`DMA_PCIE_ADDR_W-1:0] rd_desc_pcie_addr, wr_desc_pcie_addr;
    logic [`DMA_AXI_ADDR_W-1:0] rd_desc_axi_addr, wr_desc_axi_addr;
    logic [`DMA_LEN_W-1:0] rd_desc_len, wr_desc_len;
    logic [`DMA_TAG_W-1:0] rd_desc_tag, wr_desc_tag, rd_status_tag, wr_status_tag;
    logic rd_desc_valid, wr_desc_valid, rd_desc_ready, wr_desc_ready;
    logic rd_status_valid, wr_status_valid, rd_status_ready, wr_status_ready;
    logic rq_valid, rq_ready, rq_last, rc_valid, rc_ready, rc_last;
    logic cq_valid, cq_ready, cq_last, cc_valid, cc_ready, cc_last;
    logic [ERR_W-1:0] err_cor, err_uncor;

    logic [3:0] mon_valid = '0;
    logic [3:0] mon_ready = '0;
    logic [3:0] mon_last = '0;
    logic [1:0] desc_valid;
    logic [1:0] desc_ready = '0;
    logic [1:0] eng_hold = '0;
    logic [1:0] eng_seen;
    int eng_stall [2];
    logic [DESC_W-1:0] desc_bits [2];
    logic [DESC_W-1:0] eng_last [2];
    logic [DESC_W-1:0] rd_taken [$];
    logic [DESC_W-1:0] wr_taken [$];
    string dir_name [2] = '{"rd", "wr"};
    string cnt_name [4] = '{"cnt_rq", "cnt_rc", "cnt_cq", "cnt_cc"};
    int checks = 0;
    int errors = 0;
    int cor_pulses = 0;
    int uncor_pulses = 0;

    dma_ctrl_top i_dma_ctrl_top (.*);

    always #2 clk = ~clk;

    assign {cc_valid, cq_valid, rc_valid, rq_valid} = mon_valid;
    assign {cc_ready, cq_ready, rc_ready, rq_ready} = mon_ready;
    assign {cc_last, cq_last, rc_last, rq_last} = mon_last;
    assign desc_valid = {wr_desc_valid, rd_desc_valid};
    assign {wr_desc_ready, rd_desc_ready} = desc_ready;
    assign desc_bits[0] = {rd_desc_pcie_addr, rd_desc_axi_addr, rd_desc_len, rd_desc_tag};
    assign desc_bits[1] = {wr_desc_pcie_addr, wr_desc_axi_addr, wr_desc_len, wr_desc_tag};

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at %0t", what, $time);
        end
    endtask

    // DMA engine model, takes each descriptor after a random stall
    always @(negedge clk) begin
        for (int d = 0; d < 2; d++) begin
            if (rst || !desc_valid[d]) begin
                desc_ready[d] <= 1'b0;
                eng_seen[d] <= 1'b0;
                eng_stall[d] <= $urandom_range(6, 0);
            end else if (!desc_ready[d]) begin
                if (eng_seen[d]) begin
                    check_value($sformatf("%s_desc fields", dir_name[d]),
                                128'(desc_bits[d]), 128'(eng_last[d]));
                end
                eng_seen[d] <= 1'b1;
                eng_last[d] <= desc_bits[d];
                if (eng_stall[d] > 0) begin
                    eng_stall[d] <= eng_stall[d] - 1;
                end else if (!eng_hold[d]) begin
                    desc_ready[d] <= 1'b1;
                    if (d == 0) begin
                        rd_taken.push_back(desc_bits[d]);
                    end else begin
                        wr_taken.push_back(desc_bits[d]);
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (err_cor_pulse) begin
            cor_pulses++;
        end
        if (err_uncor_pulse) begin
            uncor_pulses++;
        end
    end

    task automatic reg_access(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [`REG_DATA_W-1:0] wdata,
                              output logic [`REG_DATA_W-1:0] rdata, output int stalls);
        stalls = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        #1;
        while (!req_ready) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
        check_true(rsp_valid, "no response one cycle after the request was taken");
        rdata = rsp_rdata;
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
    endtask

    task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [`REG_DATA_W-1:0] data);
        logic [`REG_DATA_W-1:0] rdata;
        int stalls;
        reg_access(1'b1, addr, data, rdata, stalls);
        check_value("rsp_rdata on write", 128'(rdata), 128'(0));
    endtask

    task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [`REG_DATA_W-1:0] data);
        int stalls;
        reg_access(1'b0, addr, '0, data, stalls);
    endtask

    task automatic launch_desc(input int d, output logic [DESC_W-1:0] desc, output int stalls);
        logic [`DMA_PCIE_ADDR_W-1:0] pcie;
        logic [`DMA_AXI_ADDR_W-1:0] axi;
        logic [`DMA_LEN_W-1:0] len;
        logic [TAG_W-1:0] tag;
        logic [`REG_DATA_W-1:0] rdata;
        pcie = {$urandom, $urandom};
        axi = $urandom;
        len = 16'($urandom);
        tag = TAG_W'($urandom);
        reg_write((d == 0) ? `REG_RD_PCIE_LO : `REG_WR_PCIE_LO, pcie[31:0]);
        reg_write((d == 0) ? `REG_RD_PCIE_HI : `REG_WR_PCIE_HI, pcie[63:32]);
        reg_write((d == 0) ? `REG_RD_AXI : `REG_WR_AXI, axi);
        reg_write((d == 0) ? `REG_RD_LEN : `REG_WR_LEN, 32'(len));
        reg_access(1'b1, (d == 0) ? `REG_RD_TAG : `REG_WR_TAG, 32'(tag), rdata, stalls);
        check_value("rsp_rdata on launch", 128'(rdata), 128'(0));
        desc = {pcie, axi, len, tag};
    endtask

    task automatic inject_completion(input int d, input logic [TAG_W-1:0] tag);
        @(negedge clk);
        if (d == 0) begin
            rd_status_valid = 1'b1;
            rd_status_tag = tag;
        end else begin
            wr_status_valid = 1'b1;
            wr_status_tag = tag;
        end
        #1;
        check_true((d == 0) ? rd_status_ready : wr_status_ready,
                   "completion queue refused a tag before it was full");
        @(negedge clk);
        rd_status_valid = 1'b0;
        wr_status_valid = 1'b0;
    endtask

    task automatic test_enable();
        logic [`REG_DATA_W-1:0] wdata;
        logic [`REG_DATA_W-1:0] rdata;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 4; i++) begin
            wdata = $urandom;
            wdata[0] = i[0];
            reg_write(`REG_DMA_CTRL, wdata);
            check_value("dma_enable", 128'(dma_enable), 128'(i[0]));
            reg_read(`REG_DMA_CTRL, rdata);
            check_value("dma ctrl rsp_rdata", 128'(rdata), 128'(wdata));
        end
        // nothing is mapped from 0x1000 up
        for (int i = 0; i < 3; i++) begin
            addr = ADDR_W'(32'h1000 | ($urandom & 32'h0ffc));
            reg_read(addr, rdata);
            check_value("unmapped rsp_rdata", 128'(rdata), 128'(0));
        end
    endtask

    task automatic test_descriptors();
        logic [DESC_W-1:0] rd_exp [$];
        logic [DESC_W-1:0] wr_exp [$];
        logic [DESC_W-1:0] desc;
        int stalls;
        eng_hold = 2'b11;
        launch_desc(0, desc, stalls);
        rd_exp.push_back(desc);
        check_value("rd_desc_valid", 128'(rd_desc_valid), 128'(1));
        check_value("wr_desc_valid", 128'(wr_desc_valid), 128'(0));
        check_value("rd_desc fields", 128'(desc_bits[0]), 128'(desc));
        launch_desc(1, desc, stalls);
        wr_exp.push_back(desc);
        check_value("wr_desc_valid", 128'(wr_desc_valid), 128'(1));
        check_value("rd_desc_valid", 128'(rd_desc_valid), 128'(1));
        check_value("wr_desc fields", 128'(desc_bits[1]), 128'(desc));
        check_value("rd_desc fields", 128'(desc_bits[0]), 128'(rd_exp[0]));
        fork
            launch_desc(0, desc, stalls);
            begin
                do begin
                    @(negedge clk);
                    #1;
                end while (!(req_valid && req_addr == `REG_RD_TAG));
                repeat (4) @(negedge clk);
                #1;
                eng_hold[0] = 1'b0;
            end
        join
        rd_exp.push_back(desc);
        check_true(stalls >= 4, "second read launch was taken while the first was pending");
        #1;
        eng_hold[1] = 1'b0;
        while (rd_taken.size() < 2 || wr_taken.size() < 1) begin
            @(negedge clk);
        end
        check_value("rd descriptors taken", 128'(rd_taken.size()), 128'(2));
        for (int i = 0; i < 2; i++) begin
            check_value($sformatf("rd_desc %0d", i), 128'(rd_taken[i]), 128'(rd_exp[i]));
        end
        check_value("wr_desc 0", 128'(wr_taken[0]), 128'(wr_exp[0]));
    endtask

    task automatic test_completions();
        logic [TAG_W-1:0] tags [$];
        logic [TAG_W-1:0] tag;
        logic [`REG_DATA_W-1:0] rdata;
        logic [ADDR_W-1:0] status_addr;
        for (int d = 0; d < 2; d++) begin
            status_addr = (d == 0) ? `REG_RD_STATUS : `REG_WR_STATUS;
            reg_read(status_addr, rdata);
            check_value("empty status word", 128'(rdata), 128'(0));
            check_value("irq", 128'(irq), 128'(0));
            for (int i = 0; i < DEPTH; i++) begin
                tag = TAG_W'($urandom);
                tags.push_back(tag);
                inject_completion(d, tag);
            end
            #1;
            check_value($sformatf("%s_status_ready", dir_name[d]),
                        128'((d == 0) ? rd_status_ready : wr_status_ready), 128'(0));
            check_value("irq", 128'(irq), 128'(1));
            while (tags.size() > 0) begin
                tag = tags.pop_front();
                reg_read(status_addr, rdata);
                check_value($sformatf("%s status word", dir_name[d]), 128'(rdata),
                            128'({1'b1, {(`REG_DATA_W - TAG_W - 1){1'b0}}, tag}));
                check_value("irq", 128'(irq), 128'(tags.size() != 0));
            end
            reg_read(status_addr, rdata);
            check_value("drained status word", 128'(rdata), 128'(0));
        end
    endtask

    task automatic test_frames();
        int expected [4];
        logic [`REG_DATA_W-1:0] rdata;
        expected = '{0, 0, 0, 0};
        for (int c = 0; c < FRAME_BEATS; c++) begin
            @(negedge clk);
            mon_valid = 4'($urandom);
            mon_ready = 4'($urandom) | 4'($urandom);
            mon_last = 4'($urandom);
            for (int s = 0; s < 4; s++) begin
                if (mon_valid[s] && mon_ready[s] && mon_last[s]) begin
                    expected[s]++;
                end
            end
        end
        @(negedge clk);
        mon_valid = '0;
        for (int s = 0; s < 4; s++) begin
            reg_read(ADDR_W'(`REG_CNT_RQ + 4 * s), rdata);
            check_value(cnt_name[s], 128'(rdata), 128'(expected[s]));
        end
    endtask

    task automatic test_errors();
        int exp_cor;
        int exp_uncor;
        exp_cor = 0;
        exp_uncor = 0;
        // one burst every third cycle keeps the pending count bounded
        for (int b = 0; b < ERR_BURSTS; b++) begin
            @(negedge clk);
            if (b == 0) begin
                err_cor = '1;
                err_uncor = '1;
            end else begin
                err_cor = ERR_W'($urandom);
                err_uncor = ERR_W'($urandom);
            end
            exp_cor += $countones(err_cor);
            exp_uncor += $countones(err_uncor);
            @(negedge clk);
            err_cor = '0;
            err_uncor = '0;
            @(negedge clk);
        end
        do begin
            @(negedge clk);
        end while (err_cor_pulse || err_uncor_pulse);
        #1;
        check_value("err_cor_pulse count", 128'(cor_pulses), 128'(exp_cor));
        check_value("err_uncor_pulse count", 128'(uncor_pulses), 128'(exp_uncor));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h3947_2989));
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        rd_status_valid = 1'b0;
        rd_status_tag = '0;
        wr_status_valid = 1'b0;
        wr_status_tag = '0;
        err_cor = '0;
        err_uncor = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_enable();
        test_descriptors();
        test_completions();
        test_frames();
        test_errors();
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dma_ctrl_top.f */
+incdir+verilog
verilog/dma_ctrl_pkg.sv
verilog/error_pulse_merge.sv
verilog/dma_frame_counters.sv
verilog/dma_status_fifo.sv
verilog/dma_ctrl_regs.sv
verilog/dma_ctrl_top.sv
verification/tb_dma_ctrl_top.sv

/* Makefile */
TOOL     := verilator
TOP      := tb_dma_ctrl_top
FILELIST := dma_ctrl_top.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
